// ==== hdl/fp_wb_cfg.svh ====
`ifndef FP_WB_CFG_SVH
`define FP_WB_CFG_SVH

//////////////////////////////////////////////////
// writeback group size

// execution units feeding the stage
`define FP_WB_NUM_UNITS 4

// instruction id width
`define FP_WB_ID_W 4

//////////////////////////////////////////////////
// single-precision field layout

`define FP_WB_EXPO_W 8
`define FP_WB_FRAC_W 23
`define FP_WB_FLEN 32

//////////////////////////////////////////////////
// shifter widths

// leading-zero count from the units
`define FP_WB_SHIFT_W 5

// denormalizing right shift amount
`define FP_WB_RSHIFT_W 8

`endif

// ==== hdl/fp_wb_pkg.sv ====
`default_nettype none

`include "fp_wb_cfg.svh"

package fp_wb_pkg;

    // riscv frm encodings
    typedef enum logic [2:0] {
        RNE = 3'b000,
        RTZ = 3'b001,
        RDN = 3'b010,
        RUP = 3'b011,
        RMM = 3'b100
    } rounding_mode_t;

    typedef struct packed {
        logic guard;
        logic round;
        logic sticky;
    } grs_t;

    typedef struct packed {
        logic                       sign;
        logic [`FP_WB_EXPO_W-1:0]   expo;
        logic [`FP_WB_FRAC_W-1:0]   frac;
    } fp_data_t;

    // one unit's unrounded result offer
    typedef struct packed {
        logic                       done;
        logic [`FP_WB_ID_W-1:0]     id;
        fp_data_t                   data;
        logic                       expo_overflow;
        logic [4:0]                 fflags;
        rounding_mode_t             rm;
        logic                       carry;
        logic                       safe;
        logic                       hidden;
        grs_t                       grs;
        logic [`FP_WB_SHIFT_W-1:0]  clz;
        logic                       subnormal;
        logic                       right_shift;
        logic [`FP_WB_RSHIFT_W-1:0] right_shift_amt;
    } fp_unit_result_t;

    // stage 1, selected offer
    typedef struct packed {
        logic                       valid;
        logic [`FP_WB_ID_W-1:0]     id;
        fp_data_t                   data;
        logic                       expo_overflow;
        logic [4:0]                 fflags;
        rounding_mode_t             rm;
        logic                       carry;
        logic                       safe;
        logic                       hidden;
        grs_t                       grs;
        logic [`FP_WB_SHIFT_W-1:0]  clz;
        logic                       subnormal;
        logic                       right_shift;
        logic [`FP_WB_RSHIFT_W-1:0] right_shift_amt;
    } fp_normalize_packet_t;

    // stage 2, normalized value plus round decision
    typedef struct packed {
        logic                       valid;
        logic [`FP_WB_ID_W-1:0]     id;
        fp_data_t                   data;
        logic                       expo_overflow;
        logic                       hidden;
        logic                       roundup;
        logic [`FP_WB_FLEN-1:0]     result_if_overflow;
        logic [4:0]                 fflags;
    } fp_round_packet_t;

    typedef struct packed {
        logic                       valid;
        logic [`FP_WB_ID_W-1:0]     id;
        logic [`FP_WB_FLEN-1:0]     data;
    } fp_wb_packet_t;

    // fflags order is nv dz of uf nx
    typedef struct packed {
        logic                       valid;
        logic [`FP_WB_ID_W-1:0]     id;
        logic [4:0]                 fflags;
    } fflags_wb_t;

endpackage

`default_nettype wire

// ==== hdl/fp_wb_select.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fp_wb_cfg.svh"

module fp_wb_select (
    input  fp_wb_pkg::fp_unit_result_t      unit_results [`FP_WB_NUM_UNITS],
    output fp_wb_pkg::fp_normalize_packet_t norm_packet,
    output logic [`FP_WB_NUM_UNITS-1:0]     ack
);

    localparam int SEL_W = $clog2(`FP_WB_NUM_UNITS);

    logic [`FP_WB_NUM_UNITS-1:0] done_vec;
    logic [SEL_W-1:0]            sel;
    logic                        any_done;
    fp_wb_pkg::fp_unit_result_t  winner;

    //////////////////////////////////////////////////
    // fixed priority, lowest index wins

    always_comb begin
        for (int i = 0; i < `FP_WB_NUM_UNITS; i++) begin
            done_vec[i] = unit_results[i].done;
        end
    end

    assign any_done = |done_vec;

    // scan downward so the lowest done index is the last one written
    always_comb begin
        sel = '0;
        for (int i = `FP_WB_NUM_UNITS - 1; i >= 0; i--) begin
            if (done_vec[i]) begin
                sel = SEL_W'(i);
            end
        end
    end

    //////////////////////////////////////////////////
    // result mux and ack

    assign winner = unit_results[sel];

    always_comb begin
        norm_packet.valid           = any_done;
        norm_packet.id              = winner.id;
        norm_packet.data            = winner.data;
        norm_packet.expo_overflow   = winner.expo_overflow;
        norm_packet.fflags          = winner.fflags;
        norm_packet.rm              = winner.rm;
        norm_packet.carry           = winner.carry;
        norm_packet.safe            = winner.safe;
        norm_packet.hidden          = winner.hidden;
        norm_packet.grs             = winner.grs;
        norm_packet.clz             = winner.clz;
        norm_packet.subnormal       = winner.subnormal;
        norm_packet.right_shift     = winner.right_shift;
        norm_packet.right_shift_amt = winner.right_shift_amt;
    end

    // one-hot, zero when nothing is done
    always_comb begin
        ack      = '0;
        ack[sel] = any_done;
    end

endmodule

`default_nettype wire

// ==== hdl/fp_normalize.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fp_wb_cfg.svh"

module fp_normalize (
    input  logic                       sign,
    input  logic [`FP_WB_EXPO_W-1:0]   expo,
    input  logic                       expo_overflow,
    input  logic [`FP_WB_FRAC_W-1:0]   frac,
    input  logic [`FP_WB_SHIFT_W-1:0]  left_shift_amt,
    input  logic                       subnormal,
    input  logic                       right_shift,
    input  logic [`FP_WB_RSHIFT_W-1:0] right_shift_amt,
    input  logic                       hidden,
    input  logic                       safe,
    input  logic                       carry,
    input  fp_wb_pkg::grs_t            grs,
    output logic                       sign_norm,
    output logic [`FP_WB_EXPO_W-1:0]   expo_norm,
    output logic                       expo_overflow_norm,
    output logic [`FP_WB_FRAC_W-1:0]   frac_norm,
    output logic                       hidden_norm,
    output fp_wb_pkg::grs_t            grs_norm
);

    // hidden, fraction, safe, guard, round
    localparam int EXT_W = `FP_WB_FRAC_W + 4;

    logic [EXT_W-1:0]           ext;
    logic [EXT_W-1:0]           ext_left;
    logic [2*EXT_W-1:0]         ext_right;
    logic [EXT_W-1:0]           right_kept;
    logic [EXT_W-1:0]           right_lost;
    logic [`FP_WB_RSHIFT_W-1:0] rshift_clamped;
    logic [`FP_WB_EXPO_W:0]     expo_plus_one;

    // safe lands on the guard position when no shift happens
    assign ext = {hidden, frac, safe, grs.guard, grs.round};

    assign ext_left = ext << left_shift_amt;

    // anything past the full width is all sticky anyway
    assign rshift_clamped = (right_shift_amt > `FP_WB_RSHIFT_W'(EXT_W)) ?
                            `FP_WB_RSHIFT_W'(EXT_W) : right_shift_amt;
    assign ext_right      = {ext, {EXT_W{1'b0}}} >> rshift_clamped;
    assign right_kept     = ext_right[2*EXT_W-1:EXT_W];
    assign right_lost     = ext_right[EXT_W-1:0];

    assign expo_plus_one = {1'b0, expo} + 1'b1;

    assign sign_norm = sign;

    always_comb begin
        if (carry) begin
            // mantissa reached 2.0, one step right
            hidden_norm        = carry;
            frac_norm          = ext[EXT_W-1:4];
            grs_norm.guard     = ext[3];
            grs_norm.round     = ext[2];
            grs_norm.sticky    = ext[1] | ext[0] | grs.sticky;
            expo_norm          = expo_plus_one[`FP_WB_EXPO_W-1:0];
            expo_overflow_norm = expo_overflow | expo_plus_one[`FP_WB_EXPO_W] |
                                 (&expo_plus_one[`FP_WB_EXPO_W-1:0]);
        end else if (right_shift) begin
            // denormalize to the minimum exponent
            hidden_norm        = right_kept[EXT_W-1];
            frac_norm          = right_kept[EXT_W-2:3];
            grs_norm.guard     = right_kept[2];
            grs_norm.round     = right_kept[1];
            grs_norm.sticky    = right_kept[0] | (|right_lost) | grs.sticky;
            expo_norm          = '0;
            expo_overflow_norm = 1'b0;
        end else begin
            hidden_norm        = ext_left[EXT_W-1];
            frac_norm          = ext_left[EXT_W-2:3];
            grs_norm.guard     = ext_left[2];
            grs_norm.round     = ext_left[1];
            grs_norm.sticky    = ext_left[0] | grs.sticky;
            // unit clamps clz for a subnormal result, exponent pins to zero
            expo_norm          = subnormal ? '0 :
                                 expo - `FP_WB_EXPO_W'(left_shift_amt);
            expo_overflow_norm = expo_overflow;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fp_round.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fp_wb_cfg.svh"

module fp_round (
    input  logic                       sign,
    input  fp_wb_pkg::rounding_mode_t  rm,
    input  fp_wb_pkg::grs_t            grs,
    input  logic                       lsb,
    output logic                       roundup,
    output logic [`FP_WB_FLEN-1:0]     result_if_overflow
);

    logic inexact;
    logic toward_zero;

    assign inexact = grs.guard | grs.round | grs.sticky;

    //////////////////////////////////////////////////
    // round-up decision per mode

    always_comb begin
        case (rm)
            fp_wb_pkg::RNE: roundup = grs.guard & (grs.round | grs.sticky | lsb);
            fp_wb_pkg::RTZ: roundup = 1'b0;
            fp_wb_pkg::RDN: roundup = sign & inexact;
            fp_wb_pkg::RUP: roundup = ~sign & inexact;
            fp_wb_pkg::RMM: roundup = grs.guard;
            default:        roundup = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////
    // saturated value on exponent overflow

    // modes that round toward zero for this sign stop at max finite
    assign toward_zero = (rm == fp_wb_pkg::RTZ) |
                         ((rm == fp_wb_pkg::RDN) & ~sign) |
                         ((rm == fp_wb_pkg::RUP) & sign);

    assign result_if_overflow = toward_zero ?
        {sign, {(`FP_WB_EXPO_W-1){1'b1}}, 1'b0, {`FP_WB_FRAC_W{1'b1}}} :
        {sign, {`FP_WB_EXPO_W{1'b1}}, {`FP_WB_FRAC_W{1'b0}}};

endmodule

`default_nettype wire

// ==== hdl/fp_writeback.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fp_wb_cfg.svh"

module fp_writeback (
    input  logic                           clk,
    input  logic                           rst,
    input  fp_wb_pkg::fp_unit_result_t     unit_results [`FP_WB_NUM_UNITS],
    output logic [`FP_WB_NUM_UNITS-1:0]    ack,
    output fp_wb_pkg::fp_wb_packet_t       wb_packet,
    output fp_wb_pkg::fflags_wb_t          fflags_wb,
    output fp_wb_pkg::fp_wb_packet_t       wb_snoop
);

    fp_wb_pkg::fp_normalize_packet_t norm_packet;
    fp_wb_pkg::fp_normalize_packet_t norm_packet_r;
    fp_wb_pkg::fp_round_packet_t     round_packet;
    fp_wb_pkg::fp_round_packet_t     round_packet_r;

    logic                     sign_norm;
    logic [`FP_WB_EXPO_W-1:0] expo_norm;
    logic                     expo_overflow_norm;
    logic [`FP_WB_FRAC_W-1:0] frac_norm;
    logic                     hidden_norm;
    fp_wb_pkg::grs_t          grs_norm;
    logic                     roundup;
    logic [`FP_WB_FLEN-1:0]   result_if_overflow;

    logic [`FP_WB_FRAC_W+1:0] frac_sum;
    logic                     frac_carry;
    logic                     promote;
    logic                     expo_inc;
    logic [`FP_WB_FRAC_W-1:0] frac_out;
    logic [`FP_WB_EXPO_W:0]   expo_sum;
    logic                     overflow_exp;
    logic                     underflow_exp;
    logic [4:0]               fflags_out;

    //////////////////////////////////////////////////
    // unit select and stage 1

    fp_wb_select u_select (
        .unit_results (unit_results),
        .norm_packet  (norm_packet),
        .ack          (ack)
    );

    always_ff @(posedge clk) begin
        norm_packet_r <= norm_packet;
        if (rst) begin
            norm_packet_r.valid <= 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // shared normalize and round decision

    fp_normalize u_normalize (
        .sign               (norm_packet_r.data.sign),
        .expo               (norm_packet_r.data.expo),
        .expo_overflow      (norm_packet_r.expo_overflow),
        .frac               (norm_packet_r.data.frac),
        .left_shift_amt     (norm_packet_r.clz),
        .subnormal          (norm_packet_r.subnormal),
        .right_shift        (norm_packet_r.right_shift),
        .right_shift_amt    (norm_packet_r.right_shift_amt),
        .hidden             (norm_packet_r.hidden),
        .safe               (norm_packet_r.safe),
        .carry              (norm_packet_r.carry),
        .grs                (norm_packet_r.grs),
        .sign_norm          (sign_norm),
        .expo_norm          (expo_norm),
        .expo_overflow_norm (expo_overflow_norm),
        .frac_norm          (frac_norm),
        .hidden_norm        (hidden_norm),
        .grs_norm           (grs_norm)
    );

    fp_round u_round (
        .sign               (sign_norm),
        .rm                 (norm_packet_r.rm),
        .grs                (grs_norm),
        .lsb                (frac_norm[0]),
        .roundup            (roundup),
        .result_if_overflow (result_if_overflow)
    );

    always_comb begin
        round_packet.valid              = norm_packet_r.valid;
        round_packet.id                 = norm_packet_r.id;
        round_packet.data.sign          = sign_norm;
        round_packet.data.expo          = expo_norm;
        round_packet.data.frac          = frac_norm;
        round_packet.expo_overflow      = expo_overflow_norm;
        round_packet.hidden             = hidden_norm;
        round_packet.roundup            = roundup;
        round_packet.result_if_overflow = result_if_overflow;
        // lost bits make it inexact, invalid results keep their flags
        round_packet.fflags = {norm_packet_r.fflags[4:1],
                               norm_packet_r.fflags[0] |
                               (~norm_packet_r.fflags[4] & (|grs_norm))};
    end

    always_ff @(posedge clk) begin
        round_packet_r <= round_packet;
        if (rst) begin
            round_packet_r.valid <= 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // increment, overflow select, flags

    assign frac_sum   = {1'b0, round_packet_r.hidden, round_packet_r.data.frac} +
                        (`FP_WB_FRAC_W + 2)'(round_packet_r.roundup);
    assign frac_carry = frac_sum[`FP_WB_FRAC_W+1];
    // subnormal that rounds up into the smallest normal
    assign promote    = ~round_packet_r.hidden & frac_sum[`FP_WB_FRAC_W];
    assign expo_inc   = frac_carry | promote;
    assign frac_out   = frac_carry ? frac_sum[`FP_WB_FRAC_W:1] :
                                     frac_sum[`FP_WB_FRAC_W-1:0];

    assign expo_sum     = {1'b0, round_packet_r.data.expo} + (`FP_WB_EXPO_W + 1)'(expo_inc);
    assign overflow_exp = round_packet_r.expo_overflow | expo_sum[`FP_WB_EXPO_W] |
                          (expo_inc & (&expo_sum[`FP_WB_EXPO_W-1:0]));

    assign underflow_exp = ~round_packet_r.hidden & (|frac_out);

    // overflow also raises inexact
    assign fflags_out = round_packet_r.fflags[4] ? round_packet_r.fflags :
                        round_packet_r.fflags |
                        {2'b00, overflow_exp, underflow_exp, overflow_exp};

    assign fflags_wb.valid  = round_packet_r.valid;
    assign fflags_wb.id     = round_packet_r.id;
    assign fflags_wb.fflags = fflags_out;

    assign wb_packet.valid = round_packet_r.valid;
    assign wb_packet.id    = round_packet_r.id;
    assign wb_packet.data  = overflow_exp ? round_packet_r.result_if_overflow :
                             {round_packet_r.data.sign,
                              expo_sum[`FP_WB_EXPO_W-1:0],
                              frac_out};

    //////////////////////////////////////////////////
    // store forwarding snoop, one cycle behind

    always_ff @(posedge clk) begin
        wb_snoop <= wb_packet;
        if (rst) begin
            wb_snoop.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/fp_wb_clkgen.sv ====
`timescale 1ns/1ps
`default_nettype none

module fp_wb_clkgen (
    output logic clk
);

    // 4 ns period
    localparam time HALF_PERIOD = 2ns;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== testbench/fp_wb_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fp_wb_cfg.svh"

module fp_wb_assertions (
    input logic                           clk,
    input logic                           rst,
    input fp_wb_pkg::fp_unit_result_t     unit_results [`FP_WB_NUM_UNITS],
    input logic [`FP_WB_NUM_UNITS-1:0]    ack,
    input fp_wb_pkg::fp_wb_packet_t       wb_packet,
    input fp_wb_pkg::fp_wb_packet_t       wb_snoop
);

    logic [`FP_WB_NUM_UNITS-1:0] done_vec;
    logic                        any_ack;

    always_comb begin
        for (int i = 0; i < `FP_WB_NUM_UNITS; i++) begin
            done_vec[i] = unit_results[i].done;
        end
    end

    assign any_ack = |ack;

    //////////////////////////////////////////////////
    // ack rules

    a_ack_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(ack))
        else $error("ack has more than one bit set");

    a_ack_done: assert property (@(posedge clk) disable iff (rst) (ack & ~done_vec) == '0)
        else $error("ack raised for a unit that is not done");

    //////////////////////////////////////////////////
    // output timing

    a_ack_latency: assert property (@(posedge clk) disable iff (rst)
        $past(any_ack, 2) |-> wb_packet.valid)
        else $error("acked result missing on the write port two cycles later");

    a_snoop_follow: assert property (@(posedge clk) disable iff (rst)
        $past(wb_packet.valid) |-> wb_snoop.valid)
        else $error("snoop valid did not follow the write port");

    // held reset clears all valids
    a_reset_valid: assert property (@(posedge clk)
        (rst && $past(rst)) |-> (!wb_packet.valid && !wb_snoop.valid))
        else $error("valid high during reset");

endmodule

`default_nettype wire

// ==== testbench/fp_wb_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fp_wb_cfg.svh"

module fp_wb_tb;

    localparam int NUM_OPS    = 16;
    localparam int LINE_WORDS = 17;
    localparam int CLK_PERIOD = 4;
    localparam int NUM_IDS    = 1 << `FP_WB_ID_W;

    logic                            clk;
    logic                            rst;
    fp_wb_pkg::fp_unit_result_t      unit_results [`FP_WB_NUM_UNITS];
    logic [`FP_WB_NUM_UNITS-1:0]     ack;
    fp_wb_pkg::fp_wb_packet_t        wb_packet;
    fp_wb_pkg::fflags_wb_t           fflags_wb;
    fp_wb_pkg::fp_wb_packet_t        wb_snoop;

    // one line per operation, see the column list in the file
    logic [31:0]                     golden [NUM_OPS*LINE_WORDS];
    int                              unit_queue [`FP_WB_NUM_UNITS][$];
    int                              wait_cycles [`FP_WB_NUM_UNITS];
    logic [`FP_WB_NUM_UNITS-1:0]     presenting;
    logic [`FP_WB_NUM_UNITS-1:0]     acked;
    logic [16:0]                     lfsr_state;
    int                              cycle;
    logic                            running;
    logic                            pending [NUM_IDS];
    int                              due_cycle [NUM_IDS];
    int                              id_entry [NUM_IDS];
    int                              received_count;
    fp_wb_pkg::fp_wb_packet_t        prev_wb;

    fp_wb_clkgen u_clkgen (
        .clk (clk)
    );

    fp_writeback u_dut (
        .clk          (clk),
        .rst          (rst),
        .unit_results (unit_results),
        .ack          (ack),
        .wb_packet    (wb_packet),
        .fflags_wb    (fflags_wb),
        .wb_snoop     (wb_snoop)
    );

    bind fp_writeback fp_wb_assertions u_assertions (
        .clk          (clk),
        .rst          (rst),
        .unit_results (unit_results),
        .ack          (ack),
        .wb_packet    (wb_packet),
        .wb_snoop     (wb_snoop)
    );

    //////////////////////////////////////////////////
    // helpers

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    // taps 17 and 14
    function automatic logic [16:0] lfsr_next(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    function automatic int take_random_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_state[16]);
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic fp_wb_pkg::fp_unit_result_t entry_result(input int e);
        fp_wb_pkg::fp_unit_result_t r;
        int b;
        b = e * LINE_WORDS;
        r.done            = 1'b1;
        r.id              = golden[b+2][`FP_WB_ID_W-1:0];
        r.data            = golden[b+3];
        r.expo_overflow   = golden[b+4][0];
        r.fflags          = golden[b+5][4:0];
        r.rm              = fp_wb_pkg::rounding_mode_t'(golden[b+6][2:0]);
        r.carry           = golden[b+7][0];
        r.safe            = golden[b+8][0];
        r.hidden          = golden[b+9][0];
        r.grs             = golden[b+10][2:0];
        r.clz             = golden[b+11][`FP_WB_SHIFT_W-1:0];
        r.subnormal       = golden[b+12][0];
        r.right_shift     = golden[b+13][0];
        r.right_shift_amt = golden[b+14][`FP_WB_RSHIFT_W-1:0];
        return r;
    endfunction

    function automatic fp_wb_pkg::fp_wb_packet_t expected_packet(input int e);
        fp_wb_pkg::fp_wb_packet_t p;
        p.valid = 1'b1;
        p.id    = golden[e*LINE_WORDS+2][`FP_WB_ID_W-1:0];
        p.data  = golden[e*LINE_WORDS+15];
        return p;
    endfunction

    function automatic fp_wb_pkg::fflags_wb_t expected_flags(input int e);
        fp_wb_pkg::fflags_wb_t f;
        f.valid  = 1'b1;
        f.id     = golden[e*LINE_WORDS+2][`FP_WB_ID_W-1:0];
        f.fflags = golden[e*LINE_WORDS+16][4:0];
        return f;
    endfunction

    //////////////////////////////////////////////////
    // compare tasks

    task automatic check_wb(input string name, input fp_wb_pkg::fp_wb_packet_t got,
                            input fp_wb_pkg::fp_wb_packet_t exp);
        if (got.valid !== exp.valid) begin
            report_failure($sformatf("error: %s.valid expected %h got %h",
                                     name, exp.valid, got.valid));
        end
        if (got.id !== exp.id) begin
            report_failure($sformatf("error: %s.id expected %h got %h", name, exp.id, got.id));
        end
        if (got.data !== exp.data) begin
            report_failure($sformatf("error: %s.data expected %h got %h",
                                     name, exp.data, got.data));
        end
    endtask

    task automatic check_fflags(input fp_wb_pkg::fflags_wb_t got,
                                input fp_wb_pkg::fflags_wb_t exp);
        if (got !== exp) begin
            report_failure($sformatf("error: fflags_wb expected %h got %h", exp, got));
        end
    endtask

    task automatic check_ack(input logic [`FP_WB_NUM_UNITS-1:0] got,
                             input logic [`FP_WB_NUM_UNITS-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("error: ack expected %h got %h", exp, got));
        end
    endtask

    //////////////////////////////////////////////////
    // ack sampling at the rising edge

    always @(posedge clk) begin
        logic [`FP_WB_NUM_UNITS-1:0] exp_ack;
        logic [`FP_WB_ID_W-1:0]      acked_id;
        if (running) begin
            exp_ack = '0;
            // lowest presenting unit wins
            for (int u = 0; u < `FP_WB_NUM_UNITS; u++) begin
                if (presenting[u] && exp_ack == '0) begin
                    exp_ack[u] = 1'b1;
                end
            end
            check_ack(ack, exp_ack);
            acked = ack;
            for (int u = 0; u < `FP_WB_NUM_UNITS; u++) begin
                if (ack[u]) begin
                    acked_id            = unit_results[u].id;
                    pending[acked_id]   = 1'b1;
                    due_cycle[acked_id] = cycle + 2;
                end
            end
        end
        // count the edge after booking the ack cycle
        cycle = cycle + 1;
    end

    //////////////////////////////////////////////////
    // output checks and unit models at the falling edge

    always @(negedge clk) begin
        logic [`FP_WB_ID_W-1:0] out_id;
        if (running) begin
            if (wb_packet.valid) begin
                out_id = wb_packet.id;
                if (!pending[out_id]) begin
                    report_failure("a result was written back that was never acked or came twice");
                end
                if (due_cycle[out_id] != cycle) begin
                    report_failure("a result was written back at the wrong latency");
                end
                check_wb("wb_packet", wb_packet, expected_packet(id_entry[out_id]));
                check_fflags(fflags_wb, expected_flags(id_entry[out_id]));
                pending[out_id] = 1'b0;
                received_count  = received_count + 1;
            end else if (fflags_wb.valid) begin
                report_failure("the flag port was valid without a write packet");
            end
            for (int i = 0; i < NUM_IDS; i++) begin
                if (pending[i] && due_cycle[i] < cycle) begin
                    report_failure("an acked result never reached the write port");
                end
            end
            // snoop lags the write port by one cycle
            if (prev_wb.valid) begin
                check_wb("wb_snoop", wb_snoop, prev_wb);
            end else if (wb_snoop.valid) begin
                report_failure("the snoop port was valid without a write one cycle before");
            end
            prev_wb = wb_packet;

            for (int u = 0; u < `FP_WB_NUM_UNITS; u++) begin
                if (presenting[u] && acked[u]) begin
                    presenting[u] = 1'b0;
                    void'(unit_queue[u].pop_front());
                    if (unit_queue[u].size() > 0) begin
                        wait_cycles[u] = int'(golden[unit_queue[u][0]*LINE_WORDS+1]) +
                                         take_random_bits(2);
                    end
                end
                if (!presenting[u] && unit_queue[u].size() > 0) begin
                    if (wait_cycles[u] == 0) begin
                        presenting[u] = 1'b1;
                    end else begin
                        wait_cycles[u] = wait_cycles[u] - 1;
                    end
                end
                if (presenting[u]) begin
                    unit_results[u] = entry_result(unit_queue[u][0]);
                end else begin
                    unit_results[u] = '0;
                end
            end
            acked = '0;
        end
    end

    //////////////////////////////////////////////////
    // main sequence and watchdog

    initial begin
        int   unit_idx;
        logic in_flight;
        rst            = 1'b1;
        running        = 1'b0;
        cycle          = 0;
        received_count = 0;
        lfsr_state     = 17'd98249;
        presenting     = '0;
        acked          = '0;
        prev_wb        = '0;
        for (int u = 0; u < `FP_WB_NUM_UNITS; u++) begin
            unit_results[u] = '0;
            wait_cycles[u]  = 0;
        end
        for (int i = 0; i < NUM_IDS; i++) begin
            pending[i]   = 1'b0;
            due_cycle[i] = 0;
            id_entry[i]  = 0;
        end
        $readmemh("testbench/fp_wb_golden.hex", golden);
        for (int e = 0; e < NUM_OPS; e++) begin
            unit_idx = int'(golden[e*LINE_WORDS][1:0]);
            unit_queue[unit_idx].push_back(e);
            id_entry[golden[e*LINE_WORDS+2][`FP_WB_ID_W-1:0]] = e;
        end
        for (int u = 0; u < `FP_WB_NUM_UNITS; u++) begin
            if (unit_queue[u].size() > 0) begin
                wait_cycles[u] = int'(golden[unit_queue[u][0]*LINE_WORDS+1]);
            end
        end
        @(posedge clk);
        @(negedge clk);
        if (wb_packet.valid !== 1'b0 || fflags_wb.valid !== 1'b0 ||
            wb_snoop.valid !== 1'b0) begin
            report_failure("a valid output was high or unknown during reset");
        end
        @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // unit models start on the next falling edge
        @(posedge clk);
        running = 1'b1;
        while (received_count < NUM_OPS) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);
        in_flight = 1'b0;
        for (int i = 0; i < NUM_IDS; i++) begin
            if (pending[i]) begin
                in_flight = 1'b1;
            end
        end
        if (in_flight) begin
            report_failure("a result was still in flight at the end of the run");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

    initial begin
        #(NUM_OPS * 20 * CLK_PERIOD);
        report_failure("timeout, the outputs stalled before all results were written back");
    end

endmodule

`default_nettype wire

// ==== testbench/fp_wb_golden.hex ====
// unit delay id data expo_overflow fflags rm carry safe hidden grs clz subnormal
// right_shift right_shift_amt expected_data expected_fflags
0 0 0 3F800000 0 01 0 0 0 1 0 00 0 0 00 3F800000 01
1 0 1 40000002 0 00 0 0 1 1 0 00 0 0 00 40000002 01
2 0 2 40000003 0 00 0 0 1 1 0 00 0 0 00 40000004 01
3 0 3 C0FFFFFF 0 00 1 0 1 1 7 00 0 0 00 C0FFFFFF 01
0 1 4 40FFFFFF 0 00 3 0 0 1 1 00 0 0 00 41000000 01
1 2 5 48123456 0 00 2 0 1 1 0 00 0 0 00 48123456 01
2 0 6 C8123456 0 00 2 0 0 1 2 00 0 0 00 C8123457 01
3 3 7 3F800000 0 00 4 0 1 1 0 00 0 0 00 3F800001 01
0 0 8 7F7FFFFF 0 00 0 0 1 1 4 00 0 0 00 7F800000 05
1 1 9 7F000000 1 00 1 0 0 1 0 00 0 0 00 7F7FFFFF 05
2 5 A FF000000 1 00 3 0 0 1 0 00 0 0 00 FF7FFFFF 05
3 0 B 42900001 0 00 0 0 0 0 0 03 0 0 00 41000008 00
0 2 C 00800010 0 00 0 0 0 0 0 02 1 0 00 00000040 02
1 0 D 00000001 0 00 0 0 0 1 0 00 0 1 04 00080000 03
2 1 E 40000001 0 00 0 1 0 1 0 00 0 0 00 40C00000 01
3 4 F 3F800001 0 10 0 0 1 1 0 00 0 0 00 3F800002 10

// ==== tb.f ====
+incdir+hdl
hdl/fp_wb_pkg.sv
hdl/fp_wb_select.sv
hdl/fp_normalize.sv
hdl/fp_round.sv
hdl/fp_writeback.sv
testbench/fp_wb_clkgen.sv
testbench/fp_wb_assertions.sv
testbench/fp_wb_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = fp_wb_tb
FILELIST  = tb.f
OBJ_DIR   = obj_dir
PASS_MSG  = ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass only when the pass message shows up in the output
run: compile
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
